//--- common/alut_defines.svh
/* ALUT table geometry and field map */
`ifndef ALUT_DEFINES_SVH
`define ALUT_DEFINES_SVH

// table size
`define ALUT_DEPTH        256
`define ALUT_IDX_W        8
`define ALUT_ENTRY_W      83

// entry layout: valid, last accessed time, port, mac
`define ALUT_VALID_BIT    82
`define ALUT_TIME_HI      81
`define ALUT_TIME_LO      50
`define ALUT_PORT_HI      49
`define ALUT_PORT_LO      48
`define ALUT_MAC_HI       47

`define ALUT_REQ_CREDITS  2   // sender credits after reset, same as queue depth

`endif

//--- common/alut_pkg.sv
/* ALUT table-side types */
package alut_pkg;

   // age checker fsm
   typedef enum logic [2:0] {
      age_idle          = 3'd0,
      age_inval_aged_rd = 3'd1,
      age_chk           = 3'd2,
      age_inval_aged_wr = 3'd3,
      age_inval_all     = 3'd4
   } age_state_t;

   // software commands to the age checker
   typedef enum logic [1:0] {
      cmd_none       = 2'd0,
      cmd_inval_aged = 2'd2,   // clear stale entries only
      cmd_inval_all  = 2'd3    // wipe whole table
   } alut_cmd_t;

   // address checker fsm
   typedef enum logic [1:0] {
      addr_idle     = 2'd0,
      addr_read     = 2'd1,
      addr_age_wait = 2'd2,
      addr_write    = 2'd3
   } addr_state_t;

endpackage

//--- common/alut_reg_pkg.sv
/* ALUT register map */
package alut_reg_pkg;

   // register offsets on the select/write bus
   typedef enum logic [2:0] {
      reg_ctrl       = 3'd0,
      reg_div_clk    = 3'd1,
      reg_best_bfr   = 3'd2,
      reg_status     = 3'd3,
      reg_lst_inv_lo = 3'd4,   // mac bits 31..0
      reg_lst_inv_hi = 3'd5    // port and mac bits 47..32
   } reg_addr_t;

   // status register bits
   localparam int STATUS_ACTIVE_BIT = 0;
   localparam int STATUS_INVAL_BIT  = 1;

endpackage

//--- alut/alut_mem.sv
`timescale 1ns/1ns
/* ALUT table */
`include "alut_defines.svh"

module alut_mem
(
   input  logic                       pclk9,
   input  logic                       n_p_reset9,
   input  logic                       add_check_active,   // selects port a
   input  logic [`ALUT_IDX_W-1:0]     addr_a,
   input  logic                       write_a,
   input  logic [`ALUT_ENTRY_W-1:0]   wdata_a,
   input  logic [`ALUT_IDX_W-1:0]     addr_b,
   input  logic                       write_b,
   output logic [`ALUT_ENTRY_W-1:0]   read_data
);

   logic                       valid_q [`ALUT_DEPTH];
   logic [`ALUT_ENTRY_W-2:0]   data_q  [`ALUT_DEPTH];   // time, port, mac
   logic [`ALUT_IDX_W-1:0]     addr;
   logic                       write;

   // ownership mux
   assign addr  = add_check_active ? addr_a  : addr_b;
   assign write = add_check_active ? write_a : write_b;

   always_ff @(posedge pclk9 or negedge n_p_reset9)
   begin
      if (!n_p_reset9)
      begin
         for (int i = 0; i < `ALUT_DEPTH; i++)
            valid_q[i] <= 1'b0;
      end
      else if (write)
         valid_q[addr] <= add_check_active & wdata_a[`ALUT_VALID_BIT];   // port b clears
   end

   always_ff @(posedge pclk9)
   begin
      if (write)
         data_q[addr] <= add_check_active ? wdata_a[`ALUT_VALID_BIT-1:0] : '0;
   end

   assign read_data = {valid_q[addr], data_q[addr]};   // async read

endmodule

//--- alut/alut_age_checker.sv
`timescale 1ns/1ns
/* ALUT age checker */
`include "alut_defines.svh"

module alut_age_checker
(
   input  logic                       pclk9,
   input  logic                       n_p_reset9,
   input  alut_pkg::alut_cmd_t        command,
   input  logic [7:0]                 div_clk,
   input  logic [`ALUT_ENTRY_W-1:0]   mem_read_data,
   input  logic                       check_age,        // addr checker wants a freshness answer
   input  logic [31:0]                last_accessed,
   input  logic [31:0]                best_bfr_age,
   input  logic                       add_check_active,
   output logic [31:0]                curr_time,
   output logic [`ALUT_IDX_W-1:0]     mem_addr,
   output logic                       mem_write,
   output logic [47:0]                lst_inv_mac,
   output logic [1:0]                 lst_inv_port,
   output logic                       age_confirmed,
   output logic                       age_ok,
   output logic                       inval_in_prog,
   output logic                       age_check_active
);
   import alut_pkg::*;

   age_state_t    state;
   age_state_t    nxt_state;
   logic [7:0]    clk_div_cnt;
   logic [31:0]   chk_time;       // time stamp under test
   logic [31:0]   elapsed;
   logic          fresh;
   logic          entry_valid;
   logic          last_idx;

   // ----------------------------------------
   // divided time base
   // ----------------------------------------
   always_ff @(posedge pclk9 or negedge n_p_reset9)
   begin
      if (!n_p_reset9)
      begin
         clk_div_cnt <= 8'd0;
         curr_time   <= 32'd0;
      end
      else if (clk_div_cnt == div_clk)
      begin
         clk_div_cnt <= 8'd0;
         curr_time   <= curr_time + 32'd1;   // one tick per div_clk+1 cycles
      end
      else
         clk_div_cnt <= clk_div_cnt + 8'd1;
   end

   // addr checker passes its own stamp, the walk uses the table entry
   assign chk_time    = add_check_active ? last_accessed
                                         : mem_read_data[`ALUT_TIME_HI:`ALUT_TIME_LO];
   assign elapsed     = curr_time - chk_time;   // modulo subtraction, wrap safe
   assign fresh       = best_bfr_age > elapsed;
   assign entry_valid = mem_read_data[`ALUT_VALID_BIT];
   assign last_idx    = &mem_addr;

   // ----------------------------------------
   // fsm
   // ----------------------------------------
   always_comb
   begin
      nxt_state = state;
      case (state)
         age_idle:
            if (add_check_active)
            begin
               if (check_age)
                  nxt_state = age_chk;   // commands ignored while addr checker owns table
            end
            else if (command == cmd_inval_aged)
               nxt_state = age_inval_aged_rd;
            else if (command == cmd_inval_all)
               nxt_state = age_inval_all;
         age_inval_aged_rd:
            nxt_state = age_chk;
         age_chk:
            if (age_confirmed)
            begin
               if (add_check_active)
                  nxt_state = age_idle;             // answer given to addr checker
               else if (entry_valid & ~age_ok)
                  nxt_state = age_inval_aged_wr;    // stale, clear it
               else if (last_idx)
                  nxt_state = age_idle;
               else
                  nxt_state = age_inval_aged_rd;
            end
         age_inval_aged_wr:
            nxt_state = last_idx ? age_idle : age_inval_aged_rd;
         age_inval_all:
            if (last_idx)
               nxt_state = age_idle;
         default:
            nxt_state = age_idle;
      endcase
   end

   always_ff @(posedge pclk9 or negedge n_p_reset9)
   begin
      if (!n_p_reset9)
         state <= age_idle;
      else
         state <= nxt_state;
   end

   // walk index, every walk starts from 0
   always_ff @(posedge pclk9 or negedge n_p_reset9)
   begin
      if (!n_p_reset9)
         mem_addr <= '0;
      else if (state == age_idle)
         mem_addr <= '0;
      else if ((state == age_inval_all) || (nxt_state == age_inval_aged_rd))
         mem_addr <= mem_addr + 1'b1;
   end

   assign mem_write        = (state == age_inval_aged_wr) | (state == age_inval_all);
   assign age_check_active = (state != age_idle);

   // result is ready one cycle into age_chk, or straight away on a walk
   always_ff @(posedge pclk9 or negedge n_p_reset9)
   begin
      if (!n_p_reset9)
      begin
         age_confirmed <= 1'b0;
         age_ok        <= 1'b0;
      end
      else if ((state == age_inval_aged_rd) ||
               ((state == age_chk) && add_check_active && !age_confirmed))
      begin
         age_confirmed <= 1'b1;
         age_ok        <= fresh;
      end
      else
      begin
         age_confirmed <= 1'b0;   // single cycle pulse
         age_ok        <= 1'b0;
      end
   end

   // ----------------------------------------
   // invalidation tracking
   // ----------------------------------------
   always_ff @(posedge pclk9 or negedge n_p_reset9)
   begin
      if (!n_p_reset9)
      begin
         inval_in_prog <= 1'b0;
         lst_inv_mac   <= 48'd0;
         lst_inv_port  <= 2'd0;
      end
      else if (state == age_inval_aged_wr)
      begin
         inval_in_prog <= 1'b1;
         lst_inv_mac   <= mem_read_data[`ALUT_MAC_HI:0];              // entry being cleared
         lst_inv_port  <= mem_read_data[`ALUT_PORT_HI:`ALUT_PORT_LO];
      end
      else if (state == age_idle)
         inval_in_prog <= 1'b0;
   end

   a_state_legal: assert property (@(posedge pclk9) disable iff (!n_p_reset9)
      state inside {age_idle, age_inval_aged_rd, age_chk, age_inval_aged_wr, age_inval_all});

   // table is never written by both checkers
   a_no_shared_write: assert property (@(posedge pclk9) disable iff (!n_p_reset9)
      mem_write |-> !add_check_active);

endmodule

//--- alut/alut_addr_checker.sv
`timescale 1ns/1ns
/* ALUT address checker */
`include "alut_defines.svh"

module alut_addr_checker
(
   input  logic                       pclk9,
   input  logic                       n_p_reset9,
   input  logic                       req_valid,
   input  logic [47:0]                req_mac,
   input  logic [1:0]                 req_port,
   input  logic [31:0]                curr_time,
   input  logic [`ALUT_ENTRY_W-1:0]   mem_read_data,
   input  logic                       age_confirmed,
   input  logic                       age_ok,
   input  logic                       age_check_active,
   output logic                       req_credit,
   output logic                       resp_valid,
   output logic                       resp_hit,
   output logic [1:0]                 resp_port,
   output logic [`ALUT_IDX_W-1:0]     mem_addr,
   output logic                       mem_write,
   output logic [`ALUT_ENTRY_W-1:0]   mem_write_data,
   output logic                       add_check_active,
   output logic                       check_age,
   output logic [31:0]                last_accessed
);
   import alut_pkg::*;

   addr_state_t   state;
   logic [47:0]   q_mac  [`ALUT_REQ_CREDITS];
   logic [1:0]    q_port [`ALUT_REQ_CREDITS];
   logic          wr_ptr;
   logic          rd_ptr;
   logic [1:0]    q_count;
   logic          start;          // pop head and begin lookup
   logic [47:0]   cur_mac;
   logic [1:0]    cur_port;
   logic [1:0]    stored_port;    // port found in table
   logic          hit;
   logic          entry_match;

   // xor of the six mac bytes
   function automatic logic [`ALUT_IDX_W-1:0] mac_hash(input logic [47:0] mac);
      logic [`ALUT_IDX_W-1:0] h;
      h = '0;
      for (int i = 0; i < 6; i++)
         h ^= mac[i*8 +: 8];
      return h;
   endfunction

   // ----------------------------------------
   // request queue
   // ----------------------------------------
   always_ff @(posedge pclk9)
   begin
      if (req_valid)
      begin
         q_mac[wr_ptr]  <= req_mac;
         q_port[wr_ptr] <= req_port;
      end
   end

   always_ff @(posedge pclk9 or negedge n_p_reset9)
   begin
      if (!n_p_reset9)
      begin
         wr_ptr     <= 1'b0;
         rd_ptr     <= 1'b0;
         q_count    <= 2'd0;
         req_credit <= 1'b0;
      end
      else
      begin
         wr_ptr     <= wr_ptr ^ req_valid;
         rd_ptr     <= rd_ptr ^ start;
         q_count    <= q_count + {1'b0, req_valid} - {1'b0, start};
         req_credit <= start;   // credit back one cycle after pop
      end
   end

   // only start when age checker is idle so table ownership is exclusive
   assign start            = (state == addr_idle) & (q_count != 2'd0) & ~age_check_active;
   assign add_check_active = (state != addr_idle) | start;

   // ----------------------------------------
   // lookup fsm
   // ----------------------------------------
   assign entry_match = mem_read_data[`ALUT_VALID_BIT] &
                        (mem_read_data[`ALUT_MAC_HI:0] == cur_mac);

   always_ff @(posedge pclk9 or negedge n_p_reset9)
   begin
      if (!n_p_reset9)
      begin
         state <= addr_idle;
         hit   <= 1'b0;
      end
      else
         case (state)
            addr_idle:
               if (start)
                  state <= addr_read;
            addr_read:
            begin
               hit   <= 1'b0;
               state <= entry_match ? addr_age_wait : addr_write;   // miss goes straight to learn
            end
            addr_age_wait:
               if (age_confirmed)
               begin
                  hit   <= age_ok;   // stale entry counts as miss
                  state <= addr_write;
               end
            default:
               state <= addr_idle;   // write done
         endcase
   end

   // lookup payload
   always_ff @(posedge pclk9)
   begin
      if (start)
      begin
         cur_mac  <= q_mac[rd_ptr];
         cur_port <= q_port[rd_ptr];
         mem_addr <= mac_hash(q_mac[rd_ptr]);
      end
      if (state == addr_read)
      begin
         stored_port   <= mem_read_data[`ALUT_PORT_HI:`ALUT_PORT_LO];
         last_accessed <= mem_read_data[`ALUT_TIME_HI:`ALUT_TIME_LO];
      end
   end

   assign check_age      = (state == addr_age_wait);   // held until confirmed
   assign mem_write      = (state == addr_write);
   assign mem_write_data = {1'b1, curr_time, cur_port, cur_mac};   // always learn

   assign resp_valid = (state == addr_write);
   assign resp_hit   = hit;
   assign resp_port  = hit ? stored_port : 2'd0;

   a_no_push_full: assert property (@(posedge pclk9) disable iff (!n_p_reset9)
      req_valid |-> (q_count < `ALUT_REQ_CREDITS));

   a_resp_single: assert property (@(posedge pclk9) disable iff (!n_p_reset9)
      resp_valid |=> !resp_valid);

endmodule

//--- design/alut_regs.sv
`timescale 1ns/1ns
/* ALUT registers */

module alut_regs
(
   input  logic                       pclk9,
   input  logic                       n_p_reset9,
   input  logic                       reg_sel,
   input  logic                       reg_write,
   input  alut_reg_pkg::reg_addr_t    reg_addr,
   input  logic [31:0]                reg_wdata,
   input  logic                       age_check_active,
   input  logic                       inval_in_prog,
   input  logic [47:0]                lst_inv_mac,
   input  logic [1:0]                 lst_inv_port,
   output logic [31:0]                reg_rdata,
   output alut_pkg::alut_cmd_t        command,
   output logic [7:0]                 div_clk,
   output logic [31:0]                best_bfr_age
);
   import alut_pkg::*;
   import alut_reg_pkg::*;

   logic          wr_en;
   logic          inval_seen;   // sticky, cleared by next command
   logic [31:0]   status;

   assign wr_en = reg_sel & reg_write;

   always_ff @(posedge pclk9 or negedge n_p_reset9)
   begin
      if (!n_p_reset9)
      begin
         div_clk      <= 8'd0;
         best_bfr_age <= 32'd0;
         command      <= cmd_none;
         inval_seen   <= 1'b0;
      end
      else
      begin
         command <= cmd_none;   // ctrl write gives one cycle pulse
         if (wr_en)
            case (reg_addr)
               reg_ctrl:
                  if (reg_wdata[1])   // both legal commands have bit 1 set
                     command <= alut_cmd_t'(reg_wdata[1:0]);
               reg_div_clk:
                  div_clk <= reg_wdata[7:0];
               reg_best_bfr:
                  best_bfr_age <= reg_wdata;
               default:
                  ;
            endcase

         if (inval_in_prog)
            inval_seen <= 1'b1;
         else if (wr_en && (reg_addr == reg_ctrl))
            inval_seen <= 1'b0;
      end
   end

   always_comb
   begin
      status                    = '0;
      status[STATUS_ACTIVE_BIT] = age_check_active;
      status[STATUS_INVAL_BIT]  = inval_seen | inval_in_prog;
   end

   // read mux
   always_comb
   begin
      case (reg_addr)
         reg_div_clk:    reg_rdata = {24'd0, div_clk};
         reg_best_bfr:   reg_rdata = best_bfr_age;
         reg_status:     reg_rdata = status;
         reg_lst_inv_lo: reg_rdata = lst_inv_mac[31:0];
         reg_lst_inv_hi: reg_rdata = {14'd0, lst_inv_port, lst_inv_mac[47:32]};
         default:        reg_rdata = 32'd0;   // ctrl is write only
      endcase
   end

endmodule

//--- design/alut_top.sv
`timescale 1ns/1ns
/* ALUT top level */
`include "alut_defines.svh"

module alut_top
(
   input  logic                       pclk9,
   input  logic                       n_p_reset9,
   // register bus
   input  logic                       reg_sel,
   input  logic                       reg_write,
   input  alut_reg_pkg::reg_addr_t    reg_addr,
   input  logic [31:0]                reg_wdata,
   output logic [31:0]                reg_rdata,
   // requests
   input  logic                       req_valid,
   input  logic [47:0]                req_mac,
   input  logic [1:0]                 req_port,
   output logic                       req_credit,
   // responses
   output logic                       resp_valid,
   output logic                       resp_hit,
   output logic [1:0]                 resp_port
);
   import alut_pkg::*;

   alut_cmd_t                  command;
   logic [7:0]                 div_clk;
   logic [31:0]                best_bfr_age;
   logic [31:0]                curr_time;
   logic [47:0]                lst_inv_mac;
   logic [1:0]                 lst_inv_port;
   logic                       inval_in_prog;
   logic                       age_check_active;
   logic                       add_check_active;
   logic                       check_age;
   logic [31:0]                last_accessed;
   logic                       age_confirmed;
   logic                       age_ok;
   logic [`ALUT_ENTRY_W-1:0]   mem_read_data;   // shared by both checkers
   logic [`ALUT_IDX_W-1:0]     addr_a;
   logic                       write_a;
   logic [`ALUT_ENTRY_W-1:0]   wdata_a;
   logic [`ALUT_IDX_W-1:0]     addr_b;
   logic                       write_b;

   alut_regs u_regs (
      .pclk9            (pclk9),
      .n_p_reset9       (n_p_reset9),
      .reg_sel          (reg_sel),
      .reg_write        (reg_write),
      .reg_addr         (reg_addr),
      .reg_wdata        (reg_wdata),
      .age_check_active (age_check_active),
      .inval_in_prog    (inval_in_prog),
      .lst_inv_mac      (lst_inv_mac),
      .lst_inv_port     (lst_inv_port),
      .reg_rdata        (reg_rdata),
      .command          (command),
      .div_clk          (div_clk),
      .best_bfr_age     (best_bfr_age)
   );

   alut_age_checker u_age_checker (
      .pclk9            (pclk9),
      .n_p_reset9       (n_p_reset9),
      .command          (command),
      .div_clk          (div_clk),
      .mem_read_data    (mem_read_data),
      .check_age        (check_age),
      .last_accessed    (last_accessed),
      .best_bfr_age     (best_bfr_age),
      .add_check_active (add_check_active),
      .curr_time        (curr_time),
      .mem_addr         (addr_b),
      .mem_write        (write_b),
      .lst_inv_mac      (lst_inv_mac),
      .lst_inv_port     (lst_inv_port),
      .age_confirmed    (age_confirmed),
      .age_ok           (age_ok),
      .inval_in_prog    (inval_in_prog),
      .age_check_active (age_check_active)
   );

   alut_addr_checker u_addr_checker (
      .pclk9            (pclk9),
      .n_p_reset9       (n_p_reset9),
      .req_valid        (req_valid),
      .req_mac          (req_mac),
      .req_port         (req_port),
      .curr_time        (curr_time),
      .mem_read_data    (mem_read_data),
      .age_confirmed    (age_confirmed),
      .age_ok           (age_ok),
      .age_check_active (age_check_active),
      .req_credit       (req_credit),
      .resp_valid       (resp_valid),
      .resp_hit         (resp_hit),
      .resp_port        (resp_port),
      .mem_addr         (addr_a),
      .mem_write        (write_a),
      .mem_write_data   (wdata_a),
      .add_check_active (add_check_active),
      .check_age        (check_age),
      .last_accessed    (last_accessed)
   );

   // port a from address checker, port b from age checker
   alut_mem u_mem (
      .pclk9            (pclk9),
      .n_p_reset9       (n_p_reset9),
      .add_check_active (add_check_active),
      .addr_a           (addr_a),
      .write_a          (write_a),
      .wdata_a          (wdata_a),
      .addr_b           (addr_b),
      .write_b          (write_b),
      .read_data        (mem_read_data)
   );

endmodule

//--- bench/alut_tb.sv
/* ALUT testbench */
`timescale 1ns/1ns
`include "alut_defines.svh"

module alut_tb;
   import alut_pkg::*;
   import alut_reg_pkg::*;

   localparam int WAIT_LIMIT = 2000;   // cycles allowed per wait loop

   logic          pclk9;
   logic          n_p_reset9;
   logic          reg_sel;
   logic          reg_write;
   reg_addr_t     reg_addr;
   logic [31:0]   reg_wdata;
   logic [31:0]   reg_rdata;
   logic          req_valid;
   logic [47:0]   req_mac;
   logic [1:0]    req_port;
   logic          req_credit;
   logic          resp_valid;
   logic          resp_hit;
   logic [1:0]    resp_port;

   // reference table keyed by index
   logic [47:0]   model_mac  [int];
   logic [1:0]    model_port [int];
   bit            used_idx   [int];   // each test mac gets its own index
   logic          exp_hit  [64];      // expected responses in request order
   logic [1:0]    exp_port [64];
   logic [31:0]   age_limit;          // copy of best_bfr
   int            exp_wr;             // requests sent
   int            resp_count;
   int            spent;
   int            returned;
   int            credits_left;
   int            err_count;
   int            timeouts;

   alut_top dut (
      .pclk9      (pclk9),
      .n_p_reset9 (n_p_reset9),
      .reg_sel    (reg_sel),
      .reg_write  (reg_write),
      .reg_addr   (reg_addr),
      .reg_wdata  (reg_wdata),
      .reg_rdata  (reg_rdata),
      .req_valid  (req_valid),
      .req_mac    (req_mac),
      .req_port   (req_port),
      .req_credit (req_credit),
      .resp_valid (resp_valid),
      .resp_hit   (resp_hit),
      .resp_port  (resp_port)
   );

   initial
   begin
      pclk9 = 1'b0;
      forever
         #4 pclk9 = ~pclk9;   // 8 ns period
   end

   assign credits_left = `ALUT_REQ_CREDITS - spent + returned;

   always @(posedge pclk9 or negedge n_p_reset9)
   begin
      if (!n_p_reset9)
      begin
         returned   <= 0;
         resp_count <= 0;
      end
      else
      begin
         if (req_credit)
            returned <= returned + 1;
         if (resp_valid)
            resp_count <= resp_count + 1;   // also the read pointer of exp_*
      end
   end

   // ----------------------------------------
   // checks
   // ----------------------------------------
   a_resp_match: assert property (@(posedge pclk9) disable iff (!n_p_reset9)
      resp_valid |-> (resp_hit == exp_hit[resp_count[5:0]]) &&
                     (resp_port == exp_port[resp_count[5:0]]))
   else
   begin
      err_count++;
      $display("Error: %0t response hit or port differs from reference table", $time);
   end

   a_resp_owed: assert property (@(posedge pclk9) disable iff (!n_p_reset9)
      resp_valid |-> (resp_count < exp_wr))
   else
   begin
      err_count++;
      $display("Error: %0t response without an open request", $time);
   end

   a_credit_range: assert property (@(posedge pclk9) disable iff (!n_p_reset9)
      (credits_left >= 0) && (credits_left <= `ALUT_REQ_CREDITS))
   else
   begin
      err_count++;
      $display("Error: %0t sender credits out of range: %0d", $time, credits_left);
   end

   // ----------------------------------------
   // helpers
   // ----------------------------------------
   function automatic logic [7:0] bucket_of(input logic [47:0] mac);
      return mac[7:0] ^ mac[15:8] ^ mac[23:16] ^ mac[31:24] ^ mac[39:32] ^ mac[47:40];
   endfunction

   task automatic pick_mac(output logic [47:0] mac, output logic [1:0] port);
      logic [63:0] raw;
      raw = {$urandom(), $urandom()};
      while (used_idx.exists(bucket_of(raw[47:0])))
         raw = {$urandom(), $urandom()};   // skip indices already taken
      used_idx[bucket_of(raw[47:0])] = 1'b1;
      mac  = raw[47:0];
      port = raw[49:48];
   endtask

   task automatic write_reg(input reg_addr_t addr, input logic [31:0] data);
      reg_sel   <= 1'b1;
      reg_write <= 1'b1;
      reg_addr  <= addr;
      reg_wdata <= data;
      if (addr == reg_best_bfr)
         age_limit = data;
      @(posedge pclk9);
      reg_sel   <= 1'b0;
      reg_write <= 1'b0;
   endtask

   task automatic check_reg(input reg_addr_t addr, input logic [31:0] exp);
      logic [31:0] got;
      reg_addr <= addr;
      @(negedge pclk9);
      got = reg_rdata;   // combinational read settles by mid cycle
      @(posedge pclk9);
      a_reg_value: assert (got == exp)
      else
      begin
         err_count++;
         $display("Error: %0t register %s read %h, expected %h", $time, addr.name(), got, exp);
      end
   endtask

   // spend one credit and predict the answer from the reference table
   task automatic send_req(input logic [47:0] mac, input logic [1:0] port);
      int         n;
      logic [7:0] idx;
      logic       fresh;
      n = 0;
      while ((credits_left <= 0) && (n < WAIT_LIMIT))
      begin
         req_valid <= 1'b0;
         @(posedge pclk9);
         n++;
      end
      if (n >= WAIT_LIMIT)
      begin
         timeouts++;
         $display("Timeout: no request credit came back from the DUT");
      end
      idx   = bucket_of(mac);
      fresh = (age_limit == 32'hffff_ffff);   // limit 2 at one tick per cycle is stale by lookup
      exp_hit[exp_wr[5:0]]  = model_mac.exists(idx) && (model_mac[idx] == mac) && fresh;
      exp_port[exp_wr[5:0]] = exp_hit[exp_wr[5:0]] ? model_port[idx] : 2'd0;
      model_mac[idx]  = mac;   // every lookup learns
      model_port[idx] = port;
      exp_wr++;
      spent++;
      req_valid <= 1'b1;
      req_mac   <= mac;
      req_port  <= port;
      @(posedge pclk9);
   endtask

   task automatic drain();
      int n;
      n = 0;
      req_valid <= 1'b0;
      while ((resp_count != exp_wr) && (n < WAIT_LIMIT))
      begin
         @(posedge pclk9);
         n++;
      end
      if (resp_count != exp_wr)
      begin
         timeouts++;
         $display("Timeout: %0d responses still missing", exp_wr - resp_count);
      end
   endtask

   task automatic wait_active(input logic level);
      int   n;
      logic seen;
      n    = 0;
      seen = 1'b0;
      reg_addr <= reg_status;
      while (!seen && (n < WAIT_LIMIT))
      begin
         @(negedge pclk9);
         seen = (reg_rdata[STATUS_ACTIVE_BIT] == level);
         @(posedge pclk9);
         n++;
      end
      if (!seen)
      begin
         timeouts++;
         $display("Timeout: age checker active flag never went to %0b", level);
      end
   endtask

   task automatic run_walk(input alut_cmd_t cmd);
      write_reg(reg_ctrl, {30'd0, cmd});
      wait_active(1'b1);
      wait_active(1'b0);   // walk done
      if ((cmd == cmd_inval_all) || (age_limit != 32'hffff_ffff))
      begin
         model_mac.delete();   // with limit 2 every entry is aged
         model_port.delete();
      end
   endtask

   // ----------------------------------------
   // stimulus
   // ----------------------------------------
   initial
   begin
      logic [47:0] mac_a;
      logic [1:0]  port_a;
      logic [47:0] macs  [6];
      logic [1:0]  ports [6];

      n_p_reset9 = 1'b0;
      reg_sel    = 1'b0;
      reg_write  = 1'b0;
      reg_addr   = reg_ctrl;
      reg_wdata  = 32'd0;
      req_valid  = 1'b0;
      req_mac    = 48'd0;
      req_port   = 2'd0;
      age_limit  = 32'd0;
      exp_wr     = 0;
      spent      = 0;
      err_count  = 0;
      timeouts   = 0;
      void'($urandom(32'h9cc8_757d));
      repeat (10) @(posedge pclk9);
      n_p_reset9 <= 1'b1;
      @(posedge pclk9);

      // register access
      check_reg(reg_status, 32'd0);
      write_reg(reg_div_clk, 32'h5a);
      check_reg(reg_div_clk, 32'h5a);
      write_reg(reg_best_bfr, 32'h1234_5678);
      check_reg(reg_best_bfr, 32'h1234_5678);
      write_reg(reg_div_clk, 32'd0);   // one tick per cycle once the divider wraps

      // learn then hit
      write_reg(reg_best_bfr, 32'hffff_ffff);
      pick_mac(mac_a, port_a);
      send_req(mac_a, port_a);
      send_req(mac_a, port_a + 2'd1);
      drain();

      // invalidate all
      for (int i = 0; i < 6; i++)
      begin
         pick_mac(macs[i], ports[i]);
         send_req(macs[i], ports[i]);
      end
      drain();
      run_walk(cmd_inval_all);
      for (int i = 0; i < 6; i++)
         send_req(macs[i], ports[i]);
      drain();

      // aged entry misses and its write-back is found again
      write_reg(reg_best_bfr, 32'd2);
      pick_mac(mac_a, port_a);
      send_req(mac_a, port_a);
      drain();
      repeat (100) @(posedge pclk9);
      send_req(mac_a, port_a + 2'd1);
      drain();
      write_reg(reg_best_bfr, 32'hffff_ffff);
      send_req(mac_a, port_a + 2'd2);
      drain();

      // aged invalidation walk
      run_walk(cmd_inval_all);
      write_reg(reg_best_bfr, 32'd2);
      pick_mac(mac_a, port_a);
      send_req(mac_a, port_a);
      drain();
      repeat (100) @(posedge pclk9);
      run_walk(cmd_inval_aged);
      check_reg(reg_status, 32'd1 << STATUS_INVAL_BIT);
      check_reg(reg_lst_inv_lo, mac_a[31:0]);
      check_reg(reg_lst_inv_hi, {14'd0, port_a, mac_a[47:32]});
      write_reg(reg_best_bfr, 32'hffff_ffff);   // a kept entry would now hit
      send_req(mac_a, port_a);
      drain();

      // back to back until credits run out
      for (int i = 0; i < 16; i++)
      begin
         pick_mac(mac_a, port_a);
         send_req(mac_a, port_a);
      end
      drain();

      a_resp_total: assert (resp_count == exp_wr)
      else
      begin
         err_count++;
         $display("Error: %0t %0d responses for %0d requests", $time, resp_count, exp_wr);
      end
      $display("requests %0d responses %0d errors %0d timeouts %0d",
               exp_wr, resp_count, err_count, timeouts);
      if ((err_count == 0) && (timeouts == 0))
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

//--- verilog.f
+incdir+common
common/alut_pkg.sv
common/alut_reg_pkg.sv
alut/alut_mem.sv
alut/alut_age_checker.sv
alut/alut_addr_checker.sv
design/alut_regs.sv
design/alut_top.sv
bench/alut_tb.sv

//--- Makefile
# Verilator build and run for the ALUT testbench

TOP := alut_tb
LOG := sim.log

all: run

run:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
		-f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

lint:
	verilator --lint-only -Wall --timescale 1ns/1ns -f verilog.f --top-module alut_top

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all run lint clean
